// File: logic/lce_pkg.sv
// icache fill engine shared widths, vector types and channel priority indices
`default_nettype none

package lce_pkg;

  // cache geometry
  localparam int ways_c        = 4;
  localparam int sets_c        = 64;
  localparam int block_width_c = 64;
  localparam int paddr_width_c = 22;

  // fill channels, highest index has highest priority
  localparam int num_chan_c      = 3;
  localparam int chan_cmd_c      = 0;
  localparam int chan_data_cmd_c = 1;
  localparam int chan_tr_c       = 2;

  typedef logic [$clog2(ways_c)-1:0] way_t;
  typedef logic [$clog2(sets_c)-1:0] set_idx_t;
  typedef logic [block_width_c-1:0]  block_t;
  typedef logic [paddr_width_c-1:0]  paddr_t;

  // packet layout from msb: way, set index, block
  localparam int fill_pkt_width_c = $bits(way_t) + $bits(set_idx_t) + $bits(block_t);

  typedef logic [fill_pkt_width_c-1:0] fill_pkt_t;

  typedef enum logic [1:0] {
    idle_s,
    send_req_s,
    wait_fill_s
  } miss_state_e;

endpackage

`default_nettype wire

// File: logic/fill_fifo.sv
// two-entry fill packet queue with ready/valid in and valid/yumi out
`timescale 1ns/1ns
`default_nettype none

module fill_fifo #(
  parameter int width_p = 8
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               v_i,
  input  logic [width_p-1:0] data_i,
  output logic               ready_o,
  output logic               v_o,
  output logic [width_p-1:0] data_o,
  input  logic               yumi_i
);

  logic [width_p-1:0] mem_r [2];
  logic               wptr_r;
  logic               rptr_r;
  logic               full_r;
  logic               empty_r;
  logic               enq;
  logic               deq;

  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rptr_r];

  assign enq = v_i & ~full_r;
  assign deq = yumi_i;

  // packet storage
  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      full_r  <= 1'b0;
      empty_r <= 1'b1;
    end else begin
      if (enq) begin
        wptr_r <= ~wptr_r;
      end
      if (deq) begin
        rptr_r <= ~rptr_r;
      end
      // occupancy only changes when exactly one side moves
      if (enq != deq) begin
        empty_r <= deq & (~rptr_r == wptr_r);
        full_r  <= enq & (~wptr_r == rptr_r);
      end
    end
  end

  // arbiter must not pop an empty queue
  a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o);

endmodule

`default_nettype wire

// File: logic/data_mem_arbiter.sv
// fixed-priority data memory arbiter for the fill queues with a stall watchdog
`timescale 1ns/1ns
`default_nettype none

module data_mem_arbiter #(
  parameter int timeout_limit_p = 4
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic [lce_pkg::num_chan_c-1:0]   head_v_i,
  input  lce_pkg::fill_pkt_t               head_pkt_i [lce_pkg::num_chan_c],
  output logic [lce_pkg::num_chan_c-1:0]   head_yumi_o,
  output logic                             data_mem_v_o,
  output lce_pkg::way_t                    data_mem_way_o,
  output lce_pkg::set_idx_t                data_mem_index_o,
  output lce_pkg::block_t                  data_mem_data_o,
  input  logic                             data_mem_yumi_i,
  output logic                             fill_received_o,
  output logic                             stall_timeout_o
);

  import lce_pkg::*;

  localparam int chan_idx_width_lp = $clog2(num_chan_c);
  localparam int cnt_width_lp      = $clog2(timeout_limit_p + 1);

  logic [chan_idx_width_lp-1:0] sel_idx;
  logic                         sel_v;
  fill_pkt_t                    sel_pkt;
  logic [cnt_width_lp-1:0]      stall_cnt_r;
  logic [cnt_width_lp-1:0]      stall_cnt_n;

  // later channels override earlier ones, so tr wins
  always_comb begin
    sel_v   = 1'b0;
    sel_idx = '0;
    for (int i = chan_cmd_c; i <= chan_tr_c; i++) begin
      if (head_v_i[i]) begin
        sel_v   = 1'b1;
        sel_idx = chan_idx_width_lp'(i);
      end
    end
  end

  assign sel_pkt      = head_pkt_i[sel_idx];
  assign data_mem_v_o = sel_v;
  assign {data_mem_way_o, data_mem_index_o, data_mem_data_o} = sel_pkt;

  always_comb begin
    for (int i = 0; i < num_chan_c; i++) begin
      head_yumi_o[i] = sel_v & data_mem_yumi_i & (sel_idx == chan_idx_width_lp'(i));
    end
  end

  // only data-bearing coherence channels complete a miss
  assign fill_received_o = head_yumi_o[chan_data_cmd_c] | head_yumi_o[chan_tr_c];

  // watchdog on consecutive stalled cycles
  always_comb begin
    stall_timeout_o = 1'b0;
    if (stall_cnt_r == cnt_width_lp'(timeout_limit_p)) begin
      stall_timeout_o = 1'b1;
      stall_cnt_n     = '0;
    end else if (data_mem_v_o & ~data_mem_yumi_i) begin
      stall_cnt_n = stall_cnt_r + cnt_width_lp'(1);
    end else begin
      stall_cnt_n = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stall_cnt_r <= '0;
    end else begin
      stall_cnt_r <= stall_cnt_n;
    end
  end

  // at most one pop per cycle
  a_single_yumi: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(head_yumi_o));

  // heads cannot vanish while stalled, so the timeout sees a live request
  a_timeout_with_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    stall_timeout_o |-> data_mem_v_o);

endmodule

`default_nettype wire

// File: logic/miss_tracker.sv
// miss tracker: issues one request per cache miss and holds it until the fill
`timescale 1ns/1ns
`default_nettype none

module miss_tracker (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              miss_i,
  input  lce_pkg::paddr_t   miss_addr_i,
  input  lce_pkg::way_t     lru_way_i,
  output logic              lce_req_v_o,
  output lce_pkg::paddr_t   lce_req_addr_o,
  output lce_pkg::way_t     lce_req_way_o,
  input  logic              lce_req_ready_i,
  input  logic              fill_received_i,
  input  logic              stall_timeout_i,
  output logic              cache_miss_o,
  output logic              ready_o
);

  import lce_pkg::*;

  miss_state_e state_r;
  miss_state_e state_n;
  paddr_t      addr_r;
  way_t        way_r;
  logic        capture;

  assign capture = (state_r == idle_s) & miss_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      idle_s: begin
        if (miss_i) begin
          state_n = send_req_s;
        end
      end
      send_req_s: begin
        if (lce_req_ready_i) begin
          state_n = wait_fill_s;
        end
      end
      // fill pulses outside this state are dropped
      wait_fill_s: begin
        if (fill_received_i) begin
          state_n = idle_s;
        end
      end
      default: begin
        state_n = idle_s;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= idle_s;
    end else begin
      state_r <= state_n;
    end
  end

  // request payload, loaded once per miss
  always_ff @(posedge clk_i) begin
    if (capture) begin
      addr_r <= miss_addr_i;
      way_r  <= lru_way_i;
    end
  end

  assign lce_req_v_o    = (state_r == send_req_s);
  assign lce_req_addr_o = addr_r;
  assign lce_req_way_o  = way_r;

  assign cache_miss_o = (state_r != idle_s);
  assign ready_o      = ~cache_miss_o & ~stall_timeout_i;

  // request must hold until taken
  a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_req_v_o && !lce_req_ready_i |=>
      lce_req_v_o && $stable(lce_req_addr_o) && $stable(lce_req_way_o));

endmodule

`default_nettype wire

// File: logic/icache_lce.sv
// icache lce fill side: three fill queues, data memory arbiter and miss tracker
`timescale 1ns/1ns
`default_nettype none

module icache_lce #(
  parameter int timeout_limit_p = 4
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  lce_pkg::fill_pkt_t  cmd_pkt_i,
  input  logic                cmd_v_i,
  output logic                cmd_ready_o,
  input  lce_pkg::fill_pkt_t  data_cmd_pkt_i,
  input  logic                data_cmd_v_i,
  output logic                data_cmd_ready_o,
  input  lce_pkg::fill_pkt_t  tr_pkt_i,
  input  logic                tr_v_i,
  output logic                tr_ready_o,
  output logic                data_mem_v_o,
  output lce_pkg::way_t       data_mem_way_o,
  output lce_pkg::set_idx_t   data_mem_index_o,
  output lce_pkg::block_t     data_mem_data_o,
  input  logic                data_mem_yumi_i,
  input  logic                miss_i,
  input  lce_pkg::paddr_t     miss_addr_i,
  input  lce_pkg::way_t       lru_way_i,
  output logic                lce_req_v_o,
  output lce_pkg::paddr_t     lce_req_addr_o,
  output lce_pkg::way_t       lce_req_way_o,
  input  logic                lce_req_ready_i,
  output logic                cache_miss_o,
  output logic                ready_o
);

  import lce_pkg::*;

  fill_pkt_t               chan_pkt_li [num_chan_c];
  logic [num_chan_c-1:0]   chan_v_li;
  logic [num_chan_c-1:0]   chan_ready_lo;
  fill_pkt_t               fifo_pkt_lo [num_chan_c];
  logic [num_chan_c-1:0]   fifo_v_lo;
  logic [num_chan_c-1:0]   fifo_yumi_li;
  logic                    fill_received;
  logic                    stall_timeout;

  // channel ports into indexed arrays
  assign chan_pkt_li[chan_cmd_c]      = cmd_pkt_i;
  assign chan_pkt_li[chan_data_cmd_c] = data_cmd_pkt_i;
  assign chan_pkt_li[chan_tr_c]       = tr_pkt_i;
  assign chan_v_li[chan_cmd_c]        = cmd_v_i;
  assign chan_v_li[chan_data_cmd_c]   = data_cmd_v_i;
  assign chan_v_li[chan_tr_c]         = tr_v_i;
  assign cmd_ready_o                  = chan_ready_lo[chan_cmd_c];
  assign data_cmd_ready_o             = chan_ready_lo[chan_data_cmd_c];
  assign tr_ready_o                   = chan_ready_lo[chan_tr_c];

  for (genvar i = 0; i < num_chan_c; i++) begin : g_fifo
    fill_fifo #(
      .width_p (fill_pkt_width_c)
    ) i_fill_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (chan_v_li[i]),
      .data_i  (chan_pkt_li[i]),
      .ready_o (chan_ready_lo[i]),
      .v_o     (fifo_v_lo[i]),
      .data_o  (fifo_pkt_lo[i]),
      .yumi_i  (fifo_yumi_li[i])
    );
  end

  data_mem_arbiter #(
    .timeout_limit_p (timeout_limit_p)
  ) i_data_mem_arbiter (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .head_v_i         (fifo_v_lo),
    .head_pkt_i       (fifo_pkt_lo),
    .head_yumi_o      (fifo_yumi_li),
    .data_mem_v_o     (data_mem_v_o),
    .data_mem_way_o   (data_mem_way_o),
    .data_mem_index_o (data_mem_index_o),
    .data_mem_data_o  (data_mem_data_o),
    .data_mem_yumi_i  (data_mem_yumi_i),
    .fill_received_o  (fill_received),
    .stall_timeout_o  (stall_timeout)
  );

  miss_tracker i_miss_tracker (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .miss_i          (miss_i),
    .miss_addr_i     (miss_addr_i),
    .lru_way_i       (lru_way_i),
    .lce_req_v_o     (lce_req_v_o),
    .lce_req_addr_o  (lce_req_addr_o),
    .lce_req_way_o   (lce_req_way_o),
    .lce_req_ready_i (lce_req_ready_i),
    .fill_received_i (fill_received),
    .stall_timeout_i (stall_timeout),
    .cache_miss_o    (cache_miss_o),
    .ready_o         (ready_o)
  );

endmodule

`default_nettype wire

// File: test/lce_checker.sv
// lce checker: reference model of the fill queues, watchdog and miss tracker
`timescale 1ns/1ns
`default_nettype none

module lce_checker #(
  parameter int timeout_limit_p = 4
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic [lce_pkg::num_chan_c-1:0] chan_v_i,
  input  lce_pkg::fill_pkt_t             chan_pkt_i [lce_pkg::num_chan_c],
  input  logic [lce_pkg::num_chan_c-1:0] chan_ready_i,
  input  logic                           mem_v_i,
  input  lce_pkg::way_t                  mem_way_i,
  input  lce_pkg::set_idx_t              mem_index_i,
  input  lce_pkg::block_t                mem_data_i,
  input  logic                           mem_yumi_i,
  input  logic                           miss_i,
  input  lce_pkg::paddr_t                miss_addr_i,
  input  lce_pkg::way_t                  lru_way_i,
  input  logic                           req_v_i,
  input  lce_pkg::paddr_t                req_addr_i,
  input  lce_pkg::way_t                  req_way_i,
  input  logic                           req_ready_i,
  input  logic                           cache_miss_i,
  input  logic                           ready_i,
  output int                             error_count_o,
  output int                             check_count_o,
  output logic                           drained_o
);

  import lce_pkg::*;

  localparam int idle_m = 0;
  localparam int req_m  = 1;
  localparam int wait_m = 2;

  fill_pkt_t q [num_chan_c][$];
  int        stall_cnt;
  int        miss_state;
  paddr_t    exp_addr;
  way_t      exp_way;

  task automatic compare(input string name, input fill_pkt_t got, input fill_pkt_t exp);
    check_count_o++;
    if (got !== exp) begin
      error_count_o++;
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    compare(name, fill_pkt_t'(got), fill_pkt_t'(exp));
  endtask

  always @(posedge clk_i) begin
    int       sel;
    logic     timeout;
    logic     fill;
    way_t     head_way;
    set_idx_t head_idx;
    block_t   head_blk;
    if (reset_i) begin
      for (int c = 0; c < num_chan_c; c++) begin
        q[c].delete();
      end
      stall_cnt     = 0;
      miss_state    = idle_m;
      error_count_o = 0;
      check_count_o = 0;
      drained_o     = 1'b1;
    end else begin
      sel = -1;
      for (int c = 0; c < num_chan_c; c++) begin
        if (q[c].size() != 0) begin
          sel = c;
        end
        compare_bit($sformatf("chan%0d_ready_o", c), chan_ready_i[c], q[c].size() < 2);
      end
      compare_bit("data_mem_v_o", mem_v_i, sel >= 0);
      if (sel >= 0) begin
        {head_way, head_idx, head_blk} = q[sel][0];
        compare("data_mem_way_o", fill_pkt_t'(mem_way_i), fill_pkt_t'(head_way));
        compare("data_mem_index_o", fill_pkt_t'(mem_index_i), fill_pkt_t'(head_idx));
        compare("data_mem_data_o", fill_pkt_t'(mem_data_i), fill_pkt_t'(head_blk));
      end
      timeout = (stall_cnt == timeout_limit_p);
      compare_bit("cache_miss_o", cache_miss_i, miss_state != idle_m);
      compare_bit("lce_req_v_o", req_v_i, miss_state == req_m);
      if (miss_state == req_m) begin
        compare("lce_req_addr_o", fill_pkt_t'(req_addr_i), fill_pkt_t'(exp_addr));
        compare("lce_req_way_o", fill_pkt_t'(req_way_i), fill_pkt_t'(exp_way));
      end
      compare_bit("ready_o", ready_i, (miss_state == idle_m) && !timeout);

      // watchdog restarts after firing
      if (timeout || sel < 0 || mem_yumi_i) begin
        stall_cnt = 0;
      end else begin
        stall_cnt++;
      end

      // pushes see occupancy from before this edge's pop
      fill = mem_yumi_i && (sel >= chan_data_cmd_c);
      for (int c = 0; c < num_chan_c; c++) begin
        if (chan_v_i[c] && q[c].size() < 2) begin
          q[c].push_back(chan_pkt_i[c]);
        end
      end
      if (mem_yumi_i && sel >= 0) begin
        void'(q[sel].pop_front());
      end

      case (miss_state)
        idle_m: begin
          if (miss_i) begin
            miss_state = req_m;
            exp_addr   = miss_addr_i;
            exp_way    = lru_way_i;
          end
        end
        req_m: begin
          if (req_ready_i) begin
            miss_state = wait_m;
          end
        end
        default: begin
          if (fill) begin
            miss_state = idle_m;
          end
        end
      endcase

      drained_o = (miss_state == idle_m);
      for (int c = 0; c < num_chan_c; c++) begin
        if (q[c].size() != 0) begin
          drained_o = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: test/tb_icache_lce.sv
// icache lce testbench: random fill and miss traffic checked against a reference model
`timescale 1ns/1ns
`default_nettype none

module tb_icache_lce;

  import lce_pkg::*;

  localparam int timeout_limit_lp = 4;

  logic                  clk_i;
  logic                  reset_i;
  fill_pkt_t             chan_pkt [num_chan_c];
  logic [num_chan_c-1:0] chan_v;
  logic [num_chan_c-1:0] chan_ready;
  logic                  mem_v;
  way_t                  mem_way;
  set_idx_t              mem_index;
  block_t                mem_data;
  logic                  mem_yumi;
  logic                  miss;
  paddr_t                miss_addr;
  way_t                  lru_way;
  logic                  req_v;
  paddr_t                req_addr;
  way_t                  req_way;
  logic                  req_ready;
  logic                  cache_miss;
  logic                  ready;
  int                    error_count;
  int                    check_count;
  logic                  drained;
  int                    seed;
  int                    timeouts;

  icache_lce #(
    .timeout_limit_p (timeout_limit_lp)
  ) i_icache_lce (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .cmd_pkt_i        (chan_pkt[chan_cmd_c]),
    .cmd_v_i          (chan_v[chan_cmd_c]),
    .cmd_ready_o      (chan_ready[chan_cmd_c]),
    .data_cmd_pkt_i   (chan_pkt[chan_data_cmd_c]),
    .data_cmd_v_i     (chan_v[chan_data_cmd_c]),
    .data_cmd_ready_o (chan_ready[chan_data_cmd_c]),
    .tr_pkt_i         (chan_pkt[chan_tr_c]),
    .tr_v_i           (chan_v[chan_tr_c]),
    .tr_ready_o       (chan_ready[chan_tr_c]),
    .data_mem_v_o     (mem_v),
    .data_mem_way_o   (mem_way),
    .data_mem_index_o (mem_index),
    .data_mem_data_o  (mem_data),
    .data_mem_yumi_i  (mem_yumi),
    .miss_i           (miss),
    .miss_addr_i      (miss_addr),
    .lru_way_i        (lru_way),
    .lce_req_v_o      (req_v),
    .lce_req_addr_o   (req_addr),
    .lce_req_way_o    (req_way),
    .lce_req_ready_i  (req_ready),
    .cache_miss_o     (cache_miss),
    .ready_o          (ready)
  );

  lce_checker #(
    .timeout_limit_p (timeout_limit_lp)
  ) i_lce_checker (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .chan_v_i      (chan_v),
    .chan_pkt_i    (chan_pkt),
    .chan_ready_i  (chan_ready),
    .mem_v_i       (mem_v),
    .mem_way_i     (mem_way),
    .mem_index_i   (mem_index),
    .mem_data_i    (mem_data),
    .mem_yumi_i    (mem_yumi),
    .miss_i        (miss),
    .miss_addr_i   (miss_addr),
    .lru_way_i     (lru_way),
    .req_v_i       (req_v),
    .req_addr_i    (req_addr),
    .req_way_i     (req_way),
    .req_ready_i   (req_ready),
    .cache_miss_i  (cache_miss),
    .ready_i       (ready),
    .error_count_o (error_count),
    .check_count_o (check_count),
    .drained_o     (drained)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic fill_pkt_t random_pkt();
    return fill_pkt_t'({$random(seed), $random(seed), $random(seed)});
  endfunction

  function automatic bit condition_met(input int which);
    case (which)
      0: return req_v;
      1: return !cache_miss;
      2: return !ready;
      default: return drained;
    endcase
  endfunction

  task automatic drive_random(input int yumi_pct);
    @(negedge clk_i);
    for (int c = 0; c < num_chan_c; c++) begin
      chan_v[c]   = ($unsigned($random(seed)) % 2) == 0;
      chan_pkt[c] = random_pkt();
    end
    mem_yumi  = ($unsigned($random(seed)) % 100) < yumi_pct;
    req_ready = ($unsigned($random(seed)) % 3) != 0;
    miss      = ($unsigned($random(seed)) % 8) == 0;
    miss_addr = paddr_t'($random(seed));
    lru_way   = way_t'($random(seed));
  endtask

  task automatic wait_until(input int which, input int limit, input string what, input bit feed);
    int n;
    n = 0;
    while (!condition_met(which) && n < limit) begin
      @(negedge clk_i);
      // keep a fill coming while a miss waits for its block
      if (feed) begin
        chan_v[chan_data_cmd_c]   = cache_miss;
        chan_pkt[chan_data_cmd_c] = random_pkt();
      end
      n++;
    end
    if (!condition_met(which)) begin
      timeouts++;
      $display("timeout after %0d cycles waiting for %s", limit, what);
    end
  endtask

  initial begin
    seed      = 11601;
    timeouts  = 0;
    reset_i   = 1'b1;
    chan_v    = '0;
    for (int c = 0; c < num_chan_c; c++) begin
      chan_pkt[c] = '0;
    end
    mem_yumi  = 1'b0;
    miss      = 1'b0;
    miss_addr = '0;
    lru_way   = '0;
    req_ready = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // single miss, request held back for a few cycles
    @(negedge clk_i);
    miss      = 1'b1;
    miss_addr = 22'h2a5a5;
    lru_way   = 2'd2;
    @(negedge clk_i);
    miss      = 1'b0;
    miss_addr = '0;
    wait_until(0, 10, "the miss request", 1'b0);
    repeat (3) @(negedge clk_i);
    req_ready = 1'b1;
    @(negedge clk_i);
    req_ready = 1'b0;
    // cmd fill first, it must leave the miss open
    mem_yumi                 = 1'b1;
    chan_v[chan_cmd_c]       = 1'b1;
    chan_pkt[chan_cmd_c]     = random_pkt();
    @(negedge clk_i);
    chan_v[chan_cmd_c]       = 1'b0;
    repeat (2) @(negedge clk_i);
    chan_v[chan_data_cmd_c]   = 1'b1;
    chan_pkt[chan_data_cmd_c] = random_pkt();
    @(negedge clk_i);
    chan_v[chan_data_cmd_c]   = 1'b0;
    wait_until(1, 10, "the miss to complete", 1'b0);

    // one stuck packet trips the watchdog
    mem_yumi             = 1'b0;
    chan_v[chan_cmd_c]   = 1'b1;
    chan_pkt[chan_cmd_c] = random_pkt();
    @(negedge clk_i);
    chan_v[chan_cmd_c]   = 1'b0;
    wait_until(2, 12, "the stall watchdog", 1'b0);

    repeat (600) drive_random(60);
    // rare yumi, long stalls
    repeat (300) drive_random(10);
    // memory never accepts, queues fill up
    repeat (40) drive_random(0);

    @(negedge clk_i);
    chan_v    = '0;
    miss      = 1'b0;
    mem_yumi  = 1'b1;
    req_ready = 1'b1;
    wait_until(3, 200, "all queues and misses to drain", 1'b1);

    $display("checks %0d, mismatches %0d, timeouts %0d", check_count, error_count, timeouts);
    if (error_count == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
logic/lce_pkg.sv
logic/fill_fifo.sv
logic/data_mem_arbiter.sv
logic/miss_tracker.sv
logic/icache_lce.sv
test/lce_checker.sv
test/tb_icache_lce.sv

// File: Makefile
TOOL      ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP       ?= tb_icache_lce
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the log holds the pass line
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
